/* uartPeriph.f */
+incdir+include
hw/uartPkg.sv
hw/baudGen.sv
hw/uartRec.sv
hw/uartXmit.sv
hw/uartFifo.sv
hw/uartPeriph.sv
sim/uart_props.sv
sim/uartTb.sv

/* Makefile */
# Verilator flow for the uart peripheral

VERILATOR ?= verilator
TOP       ?= uartTb
FILELIST  ?= uartPeriph.f
OBJDIR    ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
PASS_MSG  ?= >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJDIR) -o V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

/* sim/uartTb.sv */
// uart peripheral testbench
`include "uart_macros.svh"

module uartTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int bitClks = `UART_OS_TICKS * `UART_CLKS_PER_TICK;	// clk cycles per bit
	localparam int waitLimit = 4000;	// clk cycles before a wait gives up

	logic clk;
	logic reset;
	logic rx;
	logic tx;
	logic txValid;
	logic txReady;
	logic rxValid;
	logic rxReady;
	logic overrun;
	logic frameErr;
	uartPkg::dataByte txData;
	uartPkg::dataByte rxData;
	int checks;
	int errors;
	int timeouts;
	logic txStalled;	// txReady seen low during a push

	uartPeriph DUT (.clk, .reset, .rx, .tx, .txData, .txValid, .txReady,
		.rxData, .rxValid, .rxReady, .overrun, .frameErr);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns period
	end

	////////////////////
	// compare tasks
	////////////////////

	task automatic checkByte(input uartPkg::dataByte got, input uartPkg::dataByte exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic reportTimeout(input string what);
		timeouts++;
		$display("gave up waiting for %s at %0t", what, $time);
	endtask

	////////////////////
	// serial and stream drivers
	////////////////////

	// one frame on rx, lsb first, then an idle bit
	task automatic sendFrame(input uartPkg::dataByte b, input logic stopLevel);
		int i;
		rx = 1'b0;	// start
		repeat (bitClks) @(negedge clk);
		for (i = 0; i < `UART_DATA_BITS; i++)
		begin
			rx = b[i];
			repeat (bitClks) @(negedge clk);
		end
		rx = stopLevel;
		repeat (bitClks) @(negedge clk);
		rx = 1'b1;	// line back to mark
		repeat (bitClks) @(negedge clk);
	endtask

	task automatic readTxFrame(output uartPkg::dataByte b, output logic startLvl,
		output logic stopLvl, output bit found);
		logic prev;
		int n;
		int i;
		b = '0;
		startLvl = 1'bx;
		stopLvl = 1'bx;
		found = 1'b0;
		prev = tx;
		n = 0;
		while (!(prev && !tx) && n < waitLimit)
		begin
			prev = tx;
			@(negedge clk);
			n++;
		end
		if (!(prev && !tx))
		begin
			reportTimeout("a start bit on tx");
			return;
		end
		found = 1'b1;
		repeat (bitClks / 2) @(negedge clk);	// middle of start
		startLvl = tx;
		for (i = 0; i < `UART_DATA_BITS; i++)
		begin
			repeat (bitClks) @(negedge clk);
			b[i] = tx;
		end
		repeat (bitClks) @(negedge clk);
		stopLvl = tx;
	endtask

	task automatic popRx(output uartPkg::dataByte b, output bit found);
		int n;
		n = 0;
		while (rxValid !== 1'b1 && n < waitLimit)
		begin
			@(negedge clk);
			n++;
		end
		found = (rxValid === 1'b1);
		b = rxData;
		if (!found)
		begin
			reportTimeout("rxValid");
			return;
		end
		rxReady = 1'b1;	// one cycle pop
		@(negedge clk);
		rxReady = 1'b0;
	endtask

	task automatic pushTx(input uartPkg::dataByte b);
		int n;
		n = 0;
		txData = b;
		txValid = 1'b1;
		while (txReady !== 1'b1 && n < waitLimit)
		begin
			txStalled = 1'b1;	// fifo full
			@(negedge clk);
			n++;
		end
		if (txReady !== 1'b1)
			reportTimeout("txReady");
		@(negedge clk);	// taken on the edge just passed
		txValid = 1'b0;
	endtask

	////////////////////
	// directed tests
	////////////////////

	task automatic testReset();
		checkFlag(tx, 1'b1, "tx after reset");
		checkFlag(txReady, 1'b1, "txReady after reset");
		checkFlag(rxValid, 1'b0, "rxValid after reset");
		checkFlag(overrun, 1'b0, "overrun after reset");
		checkFlag(frameErr, 1'b0, "frameErr after reset");
	endtask

	task automatic testReceive();
		uartPkg::dataByte b;
		uartPkg::dataByte got;
		bit found;
		int i;
		for (i = 0; i < 8; i++)
		begin
			b = uartPkg::dataByte'($urandom);
			sendFrame(b, 1'b1);
			popRx(got, found);
			if (found)
				checkByte(got, b, "rx byte");
		end
		checkFlag(frameErr, 1'b0, "frameErr after good frames");
	endtask

	// pusher and decoder run side by side so no frame is missed
	task automatic testTransmit(input int count, input bit expectStall);
		uartPkg::dataByte q[$];
		uartPkg::dataByte got;
		logic startLvl;
		logic stopLvl;
		bit found;
		int p;
		int r;
		for (p = 0; p < count; p++)
			q.push_back(uartPkg::dataByte'($urandom));
		txStalled = 1'b0;
		fork
			for (p = 0; p < count; p++)
				pushTx(q[p]);
			for (r = 0; r < count; r++)
			begin
				readTxFrame(got, startLvl, stopLvl, found);
				if (found)
				begin
					checkFlag(startLvl, 1'b0, "tx start bit");
					checkByte(got, q[r], "tx byte");
					checkFlag(stopLvl, 1'b1, "tx stop bit");
				end
			end
		join
		if (expectStall)
			checkFlag(txStalled, 1'b1, "txReady low under back-pressure");
	endtask

	task automatic testOverrun();
		uartPkg::dataByte q[$];
		uartPkg::dataByte got;
		bit found;
		int i;
		checkFlag(overrun, 1'b0, "overrun before flood");
		for (i = 0; i <= `UART_FIFO_DEPTH; i++)	// one frame more than fits
		begin
			q.push_back(uartPkg::dataByte'($urandom));
			sendFrame(q[i], 1'b1);
		end
		checkFlag(overrun, 1'b1, "overrun after flood");
		for (i = 0; i < `UART_FIFO_DEPTH; i++)
		begin
			popRx(got, found);
			if (found)
				checkByte(got, q[i], "rx byte after overrun");
		end
		checkFlag(rxValid, 1'b0, "rxValid once drained");
	endtask

	task automatic testFrameErr();
		uartPkg::dataByte b;
		uartPkg::dataByte got;
		bit found;
		b = uartPkg::dataByte'($urandom);
		sendFrame(b, 1'b0);	// stop held low
		checkFlag(frameErr, 1'b1, "frameErr after low stop");
		checkFlag(rxValid, 1'b0, "rxValid after bad frame");
		b = uartPkg::dataByte'($urandom);
		sendFrame(b, 1'b1);
		popRx(got, found);
		if (found)
			checkByte(got, b, "rx byte after framing error");
	endtask

	initial
	begin
		checks = 0;
		errors = 0;
		timeouts = 0;
		txStalled = 1'b0;
		rx = 1'b1;	// mark
		txValid = 1'b0;
		txData = '0;
		rxReady = 1'b0;
		reset = 1'b1;
		void'($urandom(59));
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		testReset();
		testReceive();
		testTransmit(8, 1'b0);
		testTransmit(20, 1'b1);	// more than the fifo holds
		testOverrun();
		testFrameErr();
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* sim/uart_props.sv */
// uart protocol assertions

module uartProps (
	input logic clk,
	input logic reset,
	input logic sTick,
	input logic rxDoneTick,
	input logic inStop,	// receiver fsm in rxStop
	input logic rxValid,
	input logic rxReady,
	input uartPkg::dataByte rxData,
	input logic txIdle,	// transmitter fsm in txIdle
	input logic tx
);
	timeunit 1ns;
	timeprecision 1ps;

	// done pulse rides on a tick
	doneOnTick: assert property (@(posedge clk) disable iff (reset) rxDoneTick |-> sTick)
		else $error("rxDoneTick high without sTick");

	doneInStop: assert property (@(posedge clk) disable iff (reset) rxDoneTick |-> inStop)
		else $error("rxDoneTick high outside rxStop");

	// head byte held while the processor stalls
	rxHold: assert property (@(posedge clk) disable iff (reset)
		rxValid && !rxReady |=> $stable(rxData))
		else $error("rxData changed while stalled");

	txMark: assert property (@(posedge clk) disable iff (reset) txIdle |-> tx)
		else $error("tx low while transmitter idle");

endmodule

////////////////////
// attach points
////////////////////

// receiver fsm checks, stream and line tied quiet
bind uartRec uartProps recProps (.clk, .reset, .sTick, .rxDoneTick,
	.inStop(stateReg == uartPkg::rxStop), .rxValid(1'b0), .rxReady(1'b1),
	.rxData('0), .txIdle(1'b0), .tx(1'b1));

// stream and tx line checks at the top
bind uartPeriph uartProps periphProps (.clk, .reset, .sTick, .rxDoneTick(1'b0),
	.inStop(1'b1), .rxValid, .rxReady, .rxData,
	.txIdle(uXmit.stateReg == uartPkg::txIdle), .tx);

/* hw/uartPeriph.sv */
// uart peripheral top
`include "uart_macros.svh"

module uartPeriph #(
	parameter int clksPerTick = `UART_CLKS_PER_TICK	// sets the baud rate
) (
	input  logic clk,
	input  logic reset,
	// serial side
	input  logic rx,
	output logic tx,
	// transmit stream from processor
	input  uartPkg::dataByte txData,
	input  logic txValid,
	output logic txReady,	// low while tx fifo full
	// receive stream to processor
	output uartPkg::dataByte rxData,
	output logic rxValid,
	input  logic rxReady,
	// sticky status
	output logic overrun,
	output logic frameErr
);

	logic sTick;	// shared 16x time base
	logic rxDoneTick;
	logic stopOk;
	uartPkg::dataByte recByte;	// byte from receiver
	logic rxWrValid;
	logic rxWrReady;
	logic txStartValid;
	logic txStartReady;
	uartPkg::dataByte txByte;	// head of tx fifo

	////////////////////
	// serial engines
	////////////////////

	baudGen #(.clksPerTick(clksPerTick)) uBaud (
		.clk(clk),
		.reset(reset),
		.sTick(sTick)
	);

	uartRec uRec (
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.rx(rx),
		.rxDoneTick(rxDoneTick),
		.stopOk(stopOk),
		.dOut(recByte)
	);

	uartXmit uXmit (
		.clk(clk),
		.reset(reset),
		.sTick(sTick),
		.txStartValid(txStartValid),
		.txIn(txByte),
		.txStartReady(txStartReady),
		.tx(tx)
	);

	////////////////////
	// buffering
	////////////////////

	// only good frames go into the fifo
	assign rxWrValid = rxDoneTick && stopOk;

	uartFifo rxFifo (
		.clk(clk),
		.reset(reset),
		.wrValid(rxWrValid),
		.wrData(recByte),
		.wrReady(rxWrReady),
		.rdValid(rxValid),
		.rdData(rxData),
		.rdReady(rxReady)
	);

	uartFifo txFifo (
		.clk(clk),
		.reset(reset),
		.wrValid(txValid),
		.wrData(txData),
		.wrReady(txReady),
		.rdValid(txStartValid),
		.rdData(txByte),
		.rdReady(txStartReady)	// pops when transmitter loads
	);

	////////////////////
	// status flags
	////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			overrun <= 1'b0;
			frameErr <= 1'b0;
		end
		else
		begin
			if (rxWrValid && !rxWrReady)
				overrun <= 1'b1;	// fifo full, frame lost
			if (rxDoneTick && !stopOk)
				frameErr <= 1'b1;	// bad stop level
		end
	end

endmodule

/* hw/uartFifo.sv */
// byte fifo with valid/ready sides
`include "uart_macros.svh"

module uartFifo (
	input  logic clk,
	input  logic reset,
	input  logic wrValid,
	input  uartPkg::dataByte wrData,
	output logic wrReady,	// low when full, writes then dropped
	output logic rdValid,	// high when not empty
	output uartPkg::dataByte rdData,
	input  logic rdReady
);

	localparam uartPkg::fifoCount fullCount = uartPkg::fifoCount'(`UART_FIFO_DEPTH);

	uartPkg::dataByte mem [`UART_FIFO_DEPTH];	// circular buffer
	logic [`UART_FIFO_AW-1:0] wrPtr;
	logic [`UART_FIFO_AW-1:0] rdPtr;	// head entry
	uartPkg::fifoCount count;	// occupancy
	logic wrEn;
	logic rdEn;

	assign wrReady = (count != fullCount);
	assign rdValid = (count != '0);
	assign wrEn = wrValid && wrReady;
	assign rdEn = rdValid && rdReady;
	assign rdData = mem[rdPtr];	// head shown directly

	// storage
	always_ff @(posedge clk)
	begin
		if (wrEn)
			mem[wrPtr] <= wrData;
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= wrPtr + 1'b1;
			if (rdEn)
				rdPtr <= rdPtr + 1'b1;
			case ({wrEn, rdEn})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

endmodule

/* hw/uartXmit.sv */
// serial transmitter
`include "uart_macros.svh"

module uartXmit (
	input  logic clk,
	input  logic reset,
	input  logic sTick,	// 16x oversampling tick
	input  logic txStartValid,	// byte waiting in tx fifo
	input  uartPkg::dataByte txIn,
	output logic txStartReady,	// idle and on a tick
	output logic tx	// serial line
);

	localparam uartPkg::tickCount lastOs = uartPkg::tickCount'(`UART_OS_TICKS - 1);
	localparam uartPkg::tickCount lastSb = uartPkg::tickCount'(`UART_SB_TICKS - 1);
	localparam uartPkg::bitIndex lastBit = uartPkg::bitIndex'(`UART_DATA_BITS - 1);

	uartPkg::txState stateReg, stateNext;
	uartPkg::tickCount sReg, sNext;	// ticks within current bit
	uartPkg::bitIndex nReg, nNext;	// data bits sent
	uartPkg::dataByte bReg;	// outgoing bits, bit 0 on the line
	logic txReg, txNext;	// registered line level
	logic acceptByte;
	logic shiftEn;

	// taking a byte only on a tick keeps the start bit exactly 16 ticks long
	assign txStartReady = (stateReg == uartPkg::txIdle) && sTick;
	assign acceptByte = txStartValid && txStartReady;
	assign tx = txReg;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::txIdle;
			sReg <= '0;
			nReg <= '0;
			txReg <= 1'b1;	// mark level
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			txReg <= txNext;
		end
	end

	// byte load and shift out
	always_ff @(posedge clk)
	begin
		if (acceptByte)
			bReg <= txIn;
		else if (shiftEn)
			bReg <= bReg >> 1;
	end

	////////////////////
	// next state
	////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		txNext = txReg;
		shiftEn = 1'b0;
		case (stateReg)
			uartPkg::txIdle:
				if (acceptByte)
				begin
					stateNext = uartPkg::txStart;
					sNext = '0;
					txNext = 1'b0;	// start bit
				end
			uartPkg::txStart:
				if (sTick)
				begin
					if (sReg == lastOs)
					begin
						stateNext = uartPkg::txData;
						sNext = '0;
						nNext = '0;
						txNext = bReg[0];	// lsb first
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::txData:
				if (sTick)
				begin
					if (sReg == lastOs)
					begin
						sNext = '0;
						shiftEn = 1'b1;
						if (nReg == lastBit)
						begin
							stateNext = uartPkg::txStop;
							txNext = 1'b1;	// stop level
						end
						else
						begin
							nNext = nReg + 1'b1;
							txNext = bReg[1];	// next bit after shift
						end
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::txStop:
				if (sTick)
				begin
					if (sReg == lastSb)
						stateNext = uartPkg::txIdle;	// line stays high
					else
						sNext = sReg + 1'b1;
				end
			default: stateNext = uartPkg::txIdle;
		endcase
	end

endmodule

/* hw/uartRec.sv */
// oversampling serial receiver
`include "uart_macros.svh"

module uartRec (
	input  logic clk,
	input  logic reset,
	input  logic sTick,	// 16x oversampling tick
	input  logic rx,	// serial line, idles high
	output logic rxDoneTick,	// one cycle, frame finished
	output logic stopOk,	// stop level seen high, valid with rxDoneTick
	output uartPkg::dataByte dOut
);

	localparam uartPkg::tickCount midStart = uartPkg::tickCount'(`UART_OS_TICKS / 2 - 1);
	localparam uartPkg::tickCount lastOs = uartPkg::tickCount'(`UART_OS_TICKS - 1);
	localparam uartPkg::tickCount lastSb = uartPkg::tickCount'(`UART_SB_TICKS - 1);
	localparam uartPkg::bitIndex lastBit = uartPkg::bitIndex'(`UART_DATA_BITS - 1);

	uartPkg::rxState stateReg, stateNext;
	uartPkg::tickCount sReg, sNext;	// ticks within current bit
	uartPkg::bitIndex nReg, nNext;	// data bits received so far
	uartPkg::dataByte bReg;	// shift register, lsb arrives first
	logic [1:0] rxSync;	// two flop synchronizer
	logic rxIn;
	logic rxPrev;	// for edge detect
	logic fallEdge;
	logic shiftEn;

	assign rxIn = rxSync[1];
	assign fallEdge = rxPrev & ~rxIn;	// needs a high before the low
	assign dOut = bReg;

	////////////////////
	// state registers
	////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxSync <= 2'b11;	// line idle
			rxPrev <= 1'b1;
			stateReg <= uartPkg::rxIdle;
			sReg <= '0;
			nReg <= '0;
		end
		else
		begin
			rxSync <= {rxSync[0], rx};
			rxPrev <= rxIn;
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
		end
	end

	// data shift, lsb first
	always_ff @(posedge clk)
	begin
		if (shiftEn)
			bReg <= {rxIn, bReg[`UART_DATA_BITS-1:1]};
	end

	////////////////////
	// next state
	////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		shiftEn = 1'b0;
		rxDoneTick = 1'b0;
		stopOk = 1'b0;
		case (stateReg)
			uartPkg::rxIdle:
				if (fallEdge)
				begin
					stateNext = uartPkg::rxStart;	// possible start bit
					sNext = '0;
				end
			uartPkg::rxStart:
				if (sTick)
				begin
					if (sReg == midStart)	// middle of start bit
					begin
						// still low means a real start, else a glitch
						stateNext = rxIn ? uartPkg::rxIdle : uartPkg::rxData;
						sNext = '0;
						nNext = '0;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::rxData:
				if (sTick)
				begin
					if (sReg == lastOs)	// middle of data bit
					begin
						sNext = '0;
						shiftEn = 1'b1;
						if (nReg == lastBit)
							stateNext = uartPkg::rxStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			uartPkg::rxStop:
				if (sTick)
				begin
					if (sReg == lastSb)	// middle of stop bit
					begin
						stateNext = uartPkg::rxIdle;
						rxDoneTick = 1'b1;
						stopOk = rxIn;	// low here is a framing error
					end
					else
						sNext = sReg + 1'b1;
				end
			default: stateNext = uartPkg::rxIdle;
		endcase
	end

endmodule

/* hw/baudGen.sv */
// oversampling tick generator
`include "uart_macros.svh"

module baudGen #(
	parameter int clksPerTick = `UART_CLKS_PER_TICK	// clk cycles per tick
) (
	input  logic clk,
	input  logic reset,
	output logic sTick	// one cycle pulse at 16x baud
);

	// divider width, at least one bit
	localparam int cntW = (clksPerTick > 1) ? $clog2(clksPerTick) : 1;
	localparam logic [cntW-1:0] lastCnt = cntW'(clksPerTick - 1);

	logic [cntW-1:0] cntReg;	// free running, restarts on reset release

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cntReg <= '0;
			sTick <= 1'b0;	// quiet until first period done
		end
		else if (cntReg == lastCnt)
		begin
			cntReg <= '0;	// wrap
			sTick <= 1'b1;	// registered so it is glitch free
		end
		else
		begin
			cntReg <= cntReg + 1'b1;
			sTick <= 1'b0;
		end
	end

endmodule

/* hw/uartPkg.sv */
// uart shared types
`include "uart_macros.svh"

package uartPkg;

	// serial payload word
	typedef logic [`UART_DATA_BITS-1:0] dataByte;

	// tick counter inside one bit period
	typedef logic [$clog2(`UART_OS_TICKS)-1:0] tickCount;

	// which data bit of the frame
	typedef logic [$clog2(`UART_DATA_BITS)-1:0] bitIndex;

	// fifo occupancy, one bit over the pointer so full is visible
	typedef logic [`UART_FIFO_AW:0] fifoCount;

	// receiver fsm
	typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxState;

	// transmitter fsm
	typedef enum logic [1:0] {txIdle, txStart, txData, txStop} txState;

endpackage

/* include/uart_macros.svh */
// uart peripheral constants
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

////////////////////
// serial frame
////////////////////

// payload bits per frame, no parity
`define UART_DATA_BITS 8

// oversampling ticks in one bit period
`define UART_OS_TICKS 16

// ticks spent in the stop bit (16 for one stop bit)
`define UART_SB_TICKS 16

////////////////////
// buffering
////////////////////

`define UART_FIFO_DEPTH 16	// entries per direction
`define UART_FIFO_AW 4	// log2 of depth

////////////////////
// time base
////////////////////

// clk cycles per oversampling tick
// small value keeps simulation short, real designs use clk / (16 * baud)
`define UART_CLKS_PER_TICK 4

`endif
